//--- Makefile
# Verilator build and run for the POV column driver testbench

SRCS = tb.f hdl/pov_cfg.svh hdl/pov_pkg.sv hdl/spi_slave.sv hdl/spi_cmd_decoder.sv \
       hdl/column_store.sv hdl/driver_controller.sv hdl/pov_top.sv \
       tb/tb_clock.sv tb/pov_assert.sv tb/pov_tb.sv

.PHONY: run clean

run: obj_dir/Vpov_tb
	@out="$$(./obj_dir/Vpov_tb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

obj_dir/Vpov_tb: $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module pov_tb -f tb.f -o Vpov_tb

clean:
	rm -rf obj_dir

//--- hdl/column_store.sv
// Single-port column RAM shared by the SPI writer and the scanner
// Writes always win; a read waits until no write is pending
// Contents are undefined until written
`timescale 1ns/10ps
`include "pov_cfg.svh"

module column_store import pov_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  pov_wr_req_t              wr,
    output logic                     wr_gnt,
    input  pov_rd_req_t              rd,
    output logic                     rd_gnt,
    output logic [`POV_COL_BITS-1:0] rd_data,
    output logic                     rd_valid
);

    // One word per column
    logic [`POV_COL_BITS-1:0] mem [`POV_MAX_COLS];

    // Fixed priority arbiter, writer above scanner
    assign wr_gnt = wr.req;
    assign rd_gnt = rd.req && !wr.req;

    // One access per clk through the single port
    always_ff @(posedge clk) begin
        if (wr_gnt) begin
            mem[wr.addr] <= wr.data;
        end else if (rd_gnt) begin
            rd_data <= mem[rd.addr];
        end
    end

    // Read data shows up one clk after its grant
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_gnt;
        end
    end

endmodule

//--- hdl/driver_controller.sv
// Column scanner feeding serial LED driver chips
// Lane k carries column bits 8k+7 down to 8k, MSB first
// Clearing display_enable finishes the current column before idling
`timescale 1ns/10ps
`include "pov_cfg.svh"

module driver_controller import pov_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  pov_cfg_t                 cfg,
    output pov_rd_req_t              rd,
    input  logic                     rd_gnt,
    input  logic [`POV_COL_BITS-1:0] rd_data,
    input  logic                     rd_valid,
    output logic                     drv_sclk,
    output logic                     drv_lat,
    output logic                     drv_sof,
    output logic [`POV_LANES-1:0]    drv_sin,
    output logic [7:0]               drv_mux,
    output logic [7:0]               cur_col,
    output logic [15:0]              frame_count
);

    localparam int LB = `POV_LANE_BITS;
    localparam int BW = $clog2(LB);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_SHIFT,
        S_LATCH,
        S_ADVANCE
    } state_e;

    state_e                   state;
    logic                     enabled;
    logic                     rd_wait;
    logic [7:0]               col_idx;
    logic [7:0]               div_cnt;
    logic                     div_done;
    logic [BW-1:0]            bit_cnt;
    logic                     last_bit;
    logic                     sin_en;
    logic                     sr_load;
    logic                     sr_step;
    logic [`POV_COL_BITS-1:0] col_sr;

    // Zero columns counts as switched off
    assign enabled  = cfg.display_enable && (cfg.col_count != 8'd0);
    assign div_done = div_cnt >= cfg.sclk_div;
    assign last_bit = bit_cnt == BW'(LB - 1);
    assign cur_col  = col_idx;

    // Shifter control, step at the end of each high phase but the last
    assign sr_load = (state == S_FETCH) && rd_valid;
    assign sr_step = (state == S_SHIFT) && div_done && drv_sclk && !last_bit;

    // Request stays up until granted
    always_comb begin
        rd.req  = (state == S_FETCH) && !rd_wait;
        rd.addr = col_idx[POV_ADDR_BITS-1:0];
    end

    // Per-lane shift register, MSB of each lane drives the pin
    always_ff @(posedge clk) begin
        if (sr_load) begin
            col_sr <= rd_data;
        end else if (sr_step) begin
            for (int k = 0; k < `POV_LANES; k++) begin
                col_sr[k*LB +: LB] <= {col_sr[k*LB +: LB-1], 1'b0};
            end
        end
    end

    // Lanes forced low outside a column shift
    always_comb begin
        for (int k = 0; k < `POV_LANES; k++) begin
            drv_sin[k] = sin_en & col_sr[k*LB + LB - 1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            rd_wait     <= 1'b0;
            col_idx     <= 8'd0;
            div_cnt     <= 8'd0;
            bit_cnt     <= '0;
            sin_en      <= 1'b0;
            drv_sclk    <= 1'b0;
            drv_lat     <= 1'b0;
            drv_sof     <= 1'b0;
            drv_mux     <= 8'd0;
            frame_count <= 16'd0;
        end else begin
            // Single clk pulses
            drv_lat <= 1'b0;
            drv_sof <= 1'b0;
            unique case (state)
                S_IDLE: begin
                    if (enabled) begin
                        // Column count may have shrunk while idle
                        if (col_idx >= cfg.col_count) begin
                            col_idx <= 8'd0;
                        end
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (rd_gnt) begin
                        rd_wait <= 1'b1;
                    end
                    if (rd_valid) begin
                        rd_wait  <= 1'b0;
                        sin_en   <= 1'b1;
                        drv_sclk <= 1'b0;
                        div_cnt  <= 8'd0;
                        bit_cnt  <= '0;
                        state    <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    if (div_done) begin
                        div_cnt <= 8'd0;
                        if (!drv_sclk) begin
                            drv_sclk <= 1'b1;
                        end else begin
                            drv_sclk <= 1'b0;
                            if (last_bit) begin
                                // Latch with sclk already low
                                sin_en  <= 1'b0;
                                drv_lat <= 1'b1;
                                state   <= S_LATCH;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                S_LATCH: begin
                    // Row select follows the column just latched
                    drv_mux <= col_idx;
                    state   <= S_ADVANCE;
                end
                S_ADVANCE: begin
                    if (col_idx + 8'd1 >= cfg.col_count) begin
                        col_idx <= 8'd0;
                        if (enabled) begin
                            drv_sof     <= 1'b1;
                            frame_count <= frame_count + 16'd1;
                        end
                    end else begin
                        col_idx <= col_idx + 8'd1;
                    end
                    state <= enabled ? S_FETCH : S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/pov_cfg.svh
// Build-time sizing for the POV column driver
// Column word is lanes times bits per lane and must fit the 24-bit pixel field
// Frame length must equal opcode + address + pixel fields of the command
`ifndef POV_CFG_SVH
`define POV_CFG_SVH

// Serial data lanes into the LED driver chips
`define POV_LANES 3

// Bits shifted per lane for one column
`define POV_LANE_BITS 8

// One stored column word
`define POV_COL_BITS (`POV_LANES * `POV_LANE_BITS)

// Column RAM depth
`define POV_MAX_COLS 64

// SPI command and status frame length in bits
`define POV_FRAME_BITS 40

`endif

//--- hdl/pov_pkg.sv
// Shared types for the POV column driver
// Command and status words are POV_FRAME_BITS wide, MSB first on the wire
`include "pov_cfg.svh"

package pov_pkg;

    // RAM word address width
    localparam int POV_ADDR_BITS = $clog2(`POV_MAX_COLS);

    // First byte of every command frame
    typedef enum logic [7:0] {
        OP_COL_WR = 8'h01,
        OP_CFG    = 8'h02
    } pov_opcode_e;

    // Column write view
    typedef struct packed {
        pov_opcode_e              opcode;
        logic [7:0]               col_addr;
        logic [`POV_COL_BITS-1:0] pixels;
    } pov_col_wr_t;

    // Display configuration view
    typedef struct packed {
        pov_opcode_e opcode;
        logic        display_enable;
        logic [14:0] reserved;
        logic [7:0]  sclk_div;
        logic [7:0]  col_count;
    } pov_cfg_t;

    // One frame, decoded by its opcode
    typedef union packed {
        pov_col_wr_t col_wr;
        pov_cfg_t    cfg;
    } pov_cmd_u;

    // Reply shifted out on MISO
    typedef struct packed {
        logic [15:0] frame_count;
        logic [7:0]  cur_col;
        logic [7:0]  col_count;
        logic [6:0]  reserved;
        logic        display_enable;
    } pov_status_t;

    // Column RAM write port
    typedef struct packed {
        logic                     req;
        logic [POV_ADDR_BITS-1:0] addr;
        logic [`POV_COL_BITS-1:0] data;
    } pov_wr_req_t;

    // Column RAM read port
    typedef struct packed {
        logic                     req;
        logic [POV_ADDR_BITS-1:0] addr;
    } pov_rd_req_t;

endpackage

//--- hdl/pov_top.sv
// POV LED column driver top, single clock domain
// SPI pins are asynchronous and resynchronized inside the slave
`timescale 1ns/10ps
`include "pov_cfg.svh"

module pov_top import pov_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  spi_sclk,
    input  logic                  spi_cs,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    output logic                  drv_sclk,
    output logic                  drv_lat,
    output logic                  drv_sof,
    output logic [`POV_LANES-1:0] drv_sin,
    output logic [7:0]            drv_mux
);

    // SPI side
    pov_cmd_u    frame;
    logic        frame_valid;
    pov_status_t status;

    // RAM ports
    pov_wr_req_t              wr;
    logic                     wr_gnt;
    pov_rd_req_t              rd;
    logic                     rd_gnt;
    logic [`POV_COL_BITS-1:0] rd_data;
    logic                     rd_valid;

    // Config down, counters back up
    pov_cfg_t    cfg;
    logic [7:0]  cur_col;
    logic [15:0] frame_count;

    spi_slave spi_slave (
        .clk(clk),
        .rst(rst),
        .spi_sclk(spi_sclk),
        .spi_cs(spi_cs),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .status(status),
        .frame(frame),
        .frame_valid(frame_valid)
    );

    spi_cmd_decoder spi_cmd_decoder (
        .clk(clk),
        .rst(rst),
        .frame(frame),
        .frame_valid(frame_valid),
        .wr(wr),
        .wr_gnt(wr_gnt),
        .cfg(cfg),
        .cur_col(cur_col),
        .frame_count(frame_count),
        .status(status)
    );

    column_store column_store (
        .clk(clk),
        .rst(rst),
        .wr(wr),
        .wr_gnt(wr_gnt),
        .rd(rd),
        .rd_gnt(rd_gnt),
        .rd_data(rd_data),
        .rd_valid(rd_valid)
    );

    driver_controller driver_controller (
        .clk(clk),
        .rst(rst),
        .cfg(cfg),
        .rd(rd),
        .rd_gnt(rd_gnt),
        .rd_data(rd_data),
        .rd_valid(rd_valid),
        .drv_sclk(drv_sclk),
        .drv_lat(drv_lat),
        .drv_sof(drv_sof),
        .drv_sin(drv_sin),
        .drv_mux(drv_mux),
        .cur_col(cur_col),
        .frame_count(frame_count)
    );

endmodule

//--- hdl/spi_cmd_decoder.sv
// Turns received SPI frames into column writes and display config
// Unknown opcodes and out-of-range column writes are dropped silently
// A new write frame before the previous grant overwrites the pending write
`timescale 1ns/10ps
`include "pov_cfg.svh"

module spi_cmd_decoder import pov_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pov_cmd_u    frame,
    input  logic        frame_valid,
    output pov_wr_req_t wr,
    input  logic        wr_gnt,
    output pov_cfg_t    cfg,
    input  logic [7:0]  cur_col,
    input  logic [15:0] frame_count,
    output pov_status_t status
);

    logic     is_col_wr;
    logic     is_cfg;
    logic     addr_ok;
    logic     wr_take;
    logic     cfg_take;
    pov_cfg_t cfg_next;

    // Opcode sits in the same byte for both views
    assign is_col_wr = frame.col_wr.opcode == OP_COL_WR;
    assign is_cfg    = frame.cfg.opcode == OP_CFG;
    assign addr_ok   = int'(frame.col_wr.col_addr) < `POV_MAX_COLS;

    assign wr_take  = frame_valid && is_col_wr && addr_ok;
    assign cfg_take = frame_valid && is_cfg;

    // Column count cannot exceed the RAM depth
    always_comb begin
        cfg_next = frame.cfg;
        if (int'(frame.cfg.col_count) > `POV_MAX_COLS) begin
            cfg_next.col_count = 8'(`POV_MAX_COLS);
        end
    end

    // Write request held until the store grants it
    always_ff @(posedge clk) begin
        if (rst) begin
            wr.req <= 1'b0;
        end else begin
            if (wr_gnt) begin
                wr.req <= 1'b0;
            end
            // A fresh frame wins over a grant in the same cycle
            if (wr_take) begin
                wr.req <= 1'b1;
            end
        end
        if (wr_take) begin
            wr.addr <= frame.col_wr.col_addr[POV_ADDR_BITS-1:0];
            wr.data <= frame.col_wr.pixels;
        end
    end

    // Config register, disabled out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (cfg_take) begin
            cfg <= cfg_next;
        end
    end

    // Live reply word for the next SPI transfer
    always_comb begin
        status                = '0;
        status.frame_count    = frame_count;
        status.cur_col        = cur_col;
        status.col_count      = cfg.col_count;
        status.display_enable = cfg.display_enable;
    end

endmodule

//--- hdl/spi_slave.sv
// SPI mode 0 slave, oversampled in the clk domain
// spi_sclk must stay slower than clk/8
// A frame is only passed on if exactly POV_FRAME_BITS bits were clocked in
`timescale 1ns/10ps
`include "pov_cfg.svh"

module spi_slave import pov_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        spi_sclk,
    input  logic        spi_cs,
    input  logic        spi_mosi,
    output logic        spi_miso,
    input  pov_status_t status,
    output pov_cmd_u    frame,
    output logic        frame_valid
);

    localparam int FB = `POV_FRAME_BITS;
    // One spare bit so the counter saturates above FB
    localparam int CW = $clog2(FB + 1) + 1;

    // Two sync stages plus one history stage for edges
    logic [2:0]    sclk_q;
    logic [2:0]    cs_q;
    logic [1:0]    mosi_q;
    logic          sclk_rise;
    logic          sclk_fall;
    logic          cs_rise;
    logic          cs_fall;
    logic          cs_active;
    logic [CW-1:0] bit_cnt;
    logic [FB-1:0] rx_sr;
    logic [FB-1:0] tx_sr;

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign cs_rise   = cs_q[1] & ~cs_q[2];
    assign cs_fall   = ~cs_q[1] & cs_q[2];
    // Chip select is active low
    assign cs_active = ~cs_q[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_q <= 3'b000;
            cs_q   <= 3'b111;
            mosi_q <= 2'b00;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_sclk};
            cs_q   <= {cs_q[1:0], spi_cs};
            mosi_q <= {mosi_q[0], spi_mosi};
        end
    end

    // Receive side, MSB arrives first
    always_ff @(posedge clk) begin
        if (cs_active && sclk_rise) begin
            rx_sr <= {rx_sr[FB-2:0], mosi_q[1]};
        end
    end

    // Bit counter and frame strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= cs_rise && (bit_cnt == CW'(FB));
            if (cs_fall) begin
                bit_cnt <= '0;
            end else if (cs_active && sclk_rise && (bit_cnt != '1)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Shift register stays stable while cs is high
    assign frame = rx_sr;

    // Status snapshot at cs fall, advanced on each falling sclk
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_sr <= '0;
        end else if (cs_fall) begin
            tx_sr <= status;
        end else if (cs_active && sclk_fall) begin
            tx_sr <= {tx_sr[FB-2:0], 1'b0};
        end
    end

    assign spi_miso = tx_sr[FB-1];

endmodule

//--- tb.f
+incdir+hdl
hdl/pov_pkg.sv
hdl/spi_slave.sv
hdl/spi_cmd_decoder.sv
hdl/column_store.sv
hdl/driver_controller.sv
hdl/pov_top.sv
tb/tb_clock.sv
tb/pov_assert.sv
tb/pov_tb.sv

//--- tb/pov_assert.sv
// Protocol checks on the LED driver outputs, bound into driver_controller
// Only active outside reset
`timescale 1ns/10ps

module pov_assert import pov_pkg::*; (
    input logic       clk,
    input logic       rst,
    input pov_cfg_t   cfg,
    input logic       drv_sclk,
    input logic       drv_lat,
    input logic [7:0] drv_mux
);

    logic enabled;

    // Same notion of enabled as the scanner
    assign enabled = cfg.display_enable && (cfg.col_count != 8'd0);

    lat_one_clk: assert property (@(posedge clk) disable iff (rst)
        drv_lat |=> !drv_lat)
        else $error("drv_lat stayed high for more than one clk");

    lat_sclk_low: assert property (@(posedge clk) disable iff (rst)
        drv_lat |-> !drv_sclk)
        else $error("drv_sclk high while drv_lat is asserted");

    mux_in_range: assert property (@(posedge clk) disable iff (rst)
        enabled |-> (drv_mux < cfg.col_count))
        else $error("drv_mux reached col_count while enabled");

endmodule

//--- tb/pov_tb.sv
// POV column driver testbench with SPI host, RAM and config model and lane capture
// Stops at the first failed check and draws its random data from a fixed seed
`timescale 1ns/10ps
`include "pov_cfg.svh"

module pov_tb import pov_pkg::*; ();

    localparam int FB = `POV_FRAME_BITS;
    localparam int LB = `POV_LANE_BITS;
    localparam int NCOL = `POV_MAX_COLS;
    // SPI sclk half period in clks
    localparam int HALF = 8;
    localparam int N_SCAN_WR = 24;
    // Watchdog budget is frames times frame length plus margin for scanning waits
    localparam int N_FRAMES = NCOL + N_SCAN_WR + 16;
    localparam int FRAME_CLKS = 2 * HALF * (FB + 2);
    localparam int MARGIN_CLKS = 20000;

    logic clk;
    logic rst;
    logic spi_sclk;
    logic spi_cs;
    logic spi_mosi;
    logic spi_miso;
    logic drv_sclk;
    logic drv_lat;
    logic drv_sof;
    logic [`POV_LANES-1:0] drv_sin;
    logic [7:0] drv_mux;

    // RAM model keeps the previous word while a write may still race a fetch
    logic [`POV_COL_BITS-1:0] ram_new [NCOL];
    logic [`POV_COL_BITS-1:0] ram_old [NCOL];
    int wr_cyc [NCOL];
    logic m_en;
    logic [7:0] m_div;
    logic [7:0] m_cnt;
    int seed;
    int cyc = 0;
    int lat_total = 0;
    // Latches still allowed or -1 for no limit
    int lat_budget = 0;
    logic [15:0] last_fc = 16'd0;

    // Lane capture state
    logic [LB-1:0] lane_sh [`POV_LANES];
    logic sclk_prev = 1'b0;
    logic wrap_prev = 1'b0;
    int bits_in = 0;
    int phase_len = 0;
    int lat_age = 99;
    int exp_col = 0;
    int lat_col = 0;

    tb_clock clock0 (
        .clk(clk),
        .rst(rst)
    );

    pov_top dut0 (
        .clk(clk),
        .rst(rst),
        .spi_sclk(spi_sclk),
        .spi_cs(spi_cs),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .drv_sclk(drv_sclk),
        .drv_lat(drv_lat),
        .drv_sof(drv_sof),
        .drv_sin(drv_sin),
        .drv_mux(drv_mux)
    );

    bind driver_controller pov_assert pov_assert0 (
        .clk(clk),
        .rst(rst),
        .cfg(cfg),
        .drv_sclk(drv_sclk),
        .drv_lat(drv_lat),
        .drv_mux(drv_mux)
    );

    task automatic halt_failed();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic fail_with(input string why);
        $display("%s", why);
        halt_failed();
    endtask

    task automatic check_value(input string name, input logic [FB-1:0] exp,
                               input logic [FB-1:0] act);
        assert (act === exp) else begin
            $display("ERROR %s expected %0h actual %0h", name, exp, act);
            halt_failed();
        end
    endtask

    // Word may be stale only while a recent write can still race the column fetch
    task automatic check_column(input int a, input logic [`POV_COL_BITS-1:0] got);
        if (cyc - wr_cyc[a] > 16 * (int'(m_div) + 1) + 24) begin
            check_value("latched_word", ram_new[a], got);
        end else begin
            assert (got === ram_new[a] || got === ram_old[a]) else begin
                $display("ERROR latched_word expected %0h or %0h actual %0h",
                         ram_new[a], ram_old[a], got);
                halt_failed();
            end
        end
    endtask

    // Mode 0 host sending MSB first and sampling miso just before each rising sclk
    task automatic spi_xfer(input logic [FB-1:0] tx, input int nbits,
                            output logic [FB-1:0] rx);
        rx = '0;
        repeat (HALF) @(posedge clk);
        spi_cs   <= 1'b0;
        spi_mosi <= tx[FB-1];
        repeat (HALF) @(posedge clk);
        for (int i = 0; i < nbits; i++) begin
            @(negedge clk);
            rx = {rx[FB-2:0], spi_miso};
            @(posedge clk);
            spi_sclk <= 1'b1;
            repeat (HALF) @(posedge clk);
            spi_sclk <= 1'b0;
            // Bits past the frame length are padded with zero
            spi_mosi <= (i + 1 < FB) ? tx[FB-2-i] : 1'b0;
            repeat (HALF - 1) @(posedge clk);
        end
        spi_cs <= 1'b1;
    endtask

    function automatic logic [FB-1:0] col_frame(input logic [7:0] addr,
                                                input logic [`POV_COL_BITS-1:0] px);
        pov_col_wr_t f;
        f.opcode   = OP_COL_WR;
        f.col_addr = addr;
        f.pixels   = px;
        return f;
    endfunction

    function automatic logic [FB-1:0] cfg_frame(input logic en, input logic [7:0] div,
                                                input logic [7:0] cnt);
        pov_cfg_t f;
        f.opcode         = OP_CFG;
        f.display_enable = en;
        f.reserved       = 15'($random(seed));
        f.sclk_div       = div;
        f.col_count      = cnt;
        return f;
    endfunction

    // Model follows each good frame as its chip select rises
    task automatic send_col(input int addr, input logic [`POV_COL_BITS-1:0] px);
        logic [FB-1:0] rx;
        spi_xfer(col_frame(8'(addr), px), FB, rx);
        ram_old[addr] = ram_new[addr];
        ram_new[addr] = px;
        wr_cyc[addr]  = cyc;
    endtask

    task automatic send_cfg(input logic en, input logic [7:0] div, input logic [7:0] cnt);
        logic [FB-1:0] rx;
        spi_xfer(cfg_frame(en, div, cnt), FB, rx);
        m_en  = en;
        m_div = div;
        m_cnt = (cnt > 8'(NCOL)) ? 8'(NCOL) : cnt;
    endtask

    // Opcode zero is not a command, so this frame only reads status
    task automatic read_status();
        logic [FB-1:0] rx;
        pov_status_t st;
        spi_xfer({8'h00, $random(seed)}, FB, rx);
        st = rx;
        check_value("status_col_count", m_cnt, st.col_count);
        check_value("status_enable", m_en, st.display_enable);
        assert (st.frame_count >= last_fc) else fail_with("frame_count went backwards");
        last_fc = st.frame_count;
    endtask

    task automatic wait_latches(input int n);
        int target;
        target = lat_total + n;
        while (lat_total < target) @(posedge clk);
    endtask

    // Capture lanes on rising drv_sclk and check every latch
    always @(negedge clk) begin : capture
        logic [`POV_COL_BITS-1:0] got;
        cyc++;
        if (lat_age < 99) begin
            lat_age++;
        end
        if (!rst) begin
            if (drv_sclk != sclk_prev) begin
                if (drv_sclk) begin
                    // First low phase of a column follows the fetch rather than a bit
                    if (bits_in > 0) begin
                        check_value("sclk_low_clks", m_div + 1, phase_len);
                    end
                    for (int k = 0; k < `POV_LANES; k++) begin
                        lane_sh[k] = {lane_sh[k][LB-2:0], drv_sin[k]};
                    end
                    bits_in++;
                end else begin
                    check_value("sclk_high_clks", m_div + 1, phase_len);
                end
                phase_len = 0;
            end
            phase_len++;
            sclk_prev = drv_sclk;
            // Mux follows one clk after the latch and the wrap pulse one clk later
            if (lat_age == 1) begin
                check_value("drv_mux", lat_col, drv_mux);
            end
            if (drv_sof) begin
                assert (lat_age == 2 && wrap_prev) else fail_with("drv_sof outside a wrap");
            end else if (lat_age == 2 && wrap_prev) begin
                assert (!m_en) else fail_with("drv_sof missing at a column wrap");
            end
            if (drv_lat) begin
                assert (lat_budget != 0) else fail_with("drv_lat while display is disabled");
                if (lat_budget > 0) begin
                    lat_budget--;
                end
                check_value("lane_bits", LB, bits_in);
                for (int k = 0; k < `POV_LANES; k++) begin
                    got[k*LB +: LB] = lane_sh[k];
                end
                check_column(exp_col, got);
                lat_col   = exp_col;
                wrap_prev = (exp_col + 1 >= int'(m_cnt));
                exp_col   = wrap_prev ? 0 : exp_col + 1;
                bits_in   = 0;
                lat_age   = 0;
                lat_total++;
            end
        end
    end

    initial begin : watchdog
        repeat (N_FRAMES * FRAME_CLKS + MARGIN_CLKS) @(posedge clk);
        fail_with("Timeout, the test sequence did not finish in time");
    end

    initial begin : main
        logic [FB-1:0] rx;
        logic [7:0] div;
        logic [7:0] cnt;
        logic [`POV_COL_BITS-1:0] px;
        int k;
        seed     = 32'h976c18d9;
        spi_sclk = 1'b0;
        spi_cs   = 1'b1;
        spi_mosi = 1'b0;
        m_en     = 1'b0;
        m_div    = 8'd0;
        m_cnt    = 8'd0;
        @(negedge rst);
        @(negedge clk);
        // Idle outputs out of reset
        check_value("reset_drv_sclk", 0, drv_sclk);
        check_value("reset_drv_lat", 0, drv_lat);
        check_value("reset_drv_sof", 0, drv_sof);
        check_value("reset_drv_sin", 0, drv_sin);
        check_value("reset_drv_mux", 0, drv_mux);
        check_value("reset_spi_miso", 0, spi_miso);

        for (int a = 0; a < NCOL; a++) begin
            send_col(a, `POV_COL_BITS'($random(seed)));
        end
        read_status();

        div = 8'($unsigned($random(seed)) % 4);
        cnt = 8'($unsigned($random(seed)) % 7 + 2);
        send_cfg(1'b1, div, cnt);
        lat_budget = -1;
        wait_latches(2 * int'(cnt));
        read_status();

        // Writes racing the scanner for the single RAM port
        for (int n = 0; n < N_SCAN_WR; n++) begin
            send_col($unsigned($random(seed)) % int'(cnt), `POV_COL_BITS'($random(seed)));
            if (n % 8 == 7) begin
                read_status();
            end
        end
        wait_latches(2 * int'(cnt) + 1);

        // Malformed frames change neither RAM nor config
        k  = $unsigned($random(seed)) % int'(cnt);
        px = {~ram_new[k][`POV_COL_BITS-1:1], 1'b0};
        // Shifted frames whose received bits would form a valid command
        // if the bit count went unchecked, each one ending with a zero bit
        spi_xfer(col_frame(8'(k), px) >> 1, FB + 1, rx);
        spi_xfer(col_frame(8'(k), px) << 1, FB - 1, rx);
        spi_xfer(cfg_frame(1'b0, div, cnt) << 1, FB - 1, rx);
        spi_xfer({8'hA5, 8'(k), ~ram_new[k]}, FB, rx);
        spi_xfer(col_frame(8'(NCOL + k), ~ram_new[k]), FB, rx);
        wait_latches(2 * int'(cnt));
        read_status();

        // After disabling only the column in flight may still latch
        send_cfg(1'b0, div, cnt);
        repeat (HALF) @(posedge clk);
        lat_budget = 1;
        repeat (3 * (16 * (int'(div) + 1) + 8)) @(posedge clk);
        read_status();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
// Free running testbench clock, 100 ns period
// Reset is held high for the first 3 rising edges
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
